// File: Makefile
# Verilator build and run of the frame buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_cam_buf
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := SIMULATION FAILED
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "test passed"; \
	else echo "no result found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: buf_coordinator.sv
module buf_coordinator
    import cam_buf_pkg::*;
(
    input  logic      idelay_refclk,
    input  logic      reset_idelay_refclk,
    input  logic      frame_start_i,
    input  logic      writer_busy_i,
    input  logic      frame_written_i,
    input  logic      readout_start_i,
    input  logic      reader_busy_i,
    input  logic      rd_done_i,
    output logic      wr_open_o,
    output slot_t     wr_slot_o,
    output logic      rd_open_o,
    output slot_t     rd_slot_o,
    output logic      frame_avail_o,
    output slot_cnt_t stored_count_o,
    output miss_cnt_t missed_count_o
);

    slot_t     wr_ptr;     // next slot to fill
    slot_t     rd_ptr;     // oldest stored slot
    slot_cnt_t occ_cnt;    // slots writing, stored or reading
    slot_cnt_t stored_cnt; // slots with a complete frame
    miss_cnt_t miss_cnt;
    logic      slot_free;
    logic      drop;

    // ------------------------------------------------------------------
    // accept or refuse a new frame
    // ------------------------------------------------------------------
    assign slot_free = (occ_cnt < slot_cnt_t'(NUM_SLOTS));
    assign wr_open_o = frame_start_i && slot_free && !writer_busy_i;
    assign drop      = frame_start_i && !(slot_free && !writer_busy_i);
    assign wr_slot_o = wr_ptr;

    // host request only honoured when something is stored
    assign rd_open_o = readout_start_i && (stored_cnt != '0) && !reader_busy_i;
    assign rd_slot_o = rd_ptr;

    assign stored_count_o = stored_cnt;
    assign missed_count_o = miss_cnt;

    always_ff @(posedge idelay_refclk) begin
        if (reset_idelay_refclk) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            occ_cnt       <= '0;
            stored_cnt    <= '0;
            miss_cnt      <= '0;
            frame_avail_o <= 1'b0;
        end else begin
            frame_avail_o <= frame_written_i;  // slot now readable

            // ring pointers
            if (wr_open_o) begin
                wr_ptr <= (wr_ptr == slot_t'(NUM_SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_done_i) begin
                rd_ptr <= (rd_ptr == slot_t'(NUM_SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // occupancy, claimed at open and released after readout
            case ({wr_open_o, rd_done_i})
                2'b10:   occ_cnt <= occ_cnt + 1'b1;
                2'b01:   occ_cnt <= occ_cnt - 1'b1;
                default: occ_cnt <= occ_cnt;
            endcase

            case ({frame_written_i, rd_done_i})
                2'b10:   stored_cnt <= stored_cnt + 1'b1;
                2'b01:   stored_cnt <= stored_cnt - 1'b1;
                default: stored_cnt <= stored_cnt;
            endcase

            if (drop && miss_cnt != '1) begin
                miss_cnt <= miss_cnt + 1'b1;  // sticks at 255
            end
        end
    end

endmodule

// File: cam_buf_pkg.sv
package cam_buf_pkg;

    // ------------------------------------------------------------------
    // buffer geometry
    // ------------------------------------------------------------------
    localparam int NUM_SLOTS   = 4;                       // frame slots in the ring
    localparam int SLOT_WORDS  = 64;                      // words per slot, also max frame
    localparam int MEM_WORDS   = NUM_SLOTS * SLOT_WORDS;  // whole buffer depth
    localparam int WFIFO_DEPTH = 4;                       // writer staging fifo, power of 2

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------
    typedef logic [31:0] pix_word_t;   // camera word == memory word
    typedef logic [7:0]  mem_addr_t;   // word address into frame_mem
    typedef logic [1:0]  slot_t;       // ring slot index
    typedef logic [6:0]  frame_len_t;  // 1 .. SLOT_WORDS
    typedef logic [7:0]  miss_cnt_t;   // saturating drop counter
    typedef logic [2:0]  slot_cnt_t;   // 0 .. NUM_SLOTS

    // camera beat as seen at the top
    typedef struct packed {
        logic      frame_start;  // one cycle, opens a frame
        logic      valid;        // word strobe
        pix_word_t data;
    } cam_beat_t;

    // memory access request, write data travels on its own
    typedef struct packed {
        logic      req;   // held until granted
        logic      we;
        mem_addr_t addr;
    } mem_req_t;

    typedef enum logic {
        OWNER_WRITER,
        OWNER_READER
    } arb_owner_e;

    typedef enum logic {
        WR_IDLE,
        WR_ACTIVE
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_DRAIN
    } rd_state_e;

endpackage

// File: cam_buf_top.sv
module cam_buf_top
    import cam_buf_pkg::*;
(
    input  logic       idelay_refclk,
    input  logic       reset_idelay_refclk,
    input  cam_beat_t  cam_i,
    input  frame_len_t frame_len_i,
    input  logic       readout_start_i,
    output pix_word_t  out_data_o,
    output logic       out_valid_o,
    output logic       readout_done_o,
    output logic       frame_avail_o,
    output slot_cnt_t  stored_count_o,
    output miss_cnt_t  missed_count_o
);

    // ------------------------------------------------------------------
    // control between coordinator, writer and reader
    // ------------------------------------------------------------------
    logic      wr_open;
    slot_t     wr_slot;
    logic      rd_open;
    slot_t     rd_slot;
    logic      writer_busy;
    logic      reader_busy;
    logic      frame_written;

    // memory path
    mem_req_t  wr_req;
    pix_word_t wr_wdata;
    logic      wr_gnt;
    mem_req_t  rd_req;
    logic      rd_gnt;
    pix_word_t rd_data;
    logic      rd_data_valid;
    mem_req_t  mem_req;
    pix_word_t mem_wdata;
    pix_word_t mem_rdata;

    buf_coordinator coord0 (
        .idelay_refclk       (idelay_refclk),
        .reset_idelay_refclk (reset_idelay_refclk),
        .frame_start_i       (cam_i.frame_start),
        .writer_busy_i       (writer_busy),
        .frame_written_i     (frame_written),
        .readout_start_i     (readout_start_i),
        .reader_busy_i       (reader_busy),
        .rd_done_i           (readout_done_o),  // frees the slot
        .wr_open_o           (wr_open),
        .wr_slot_o           (wr_slot),
        .rd_open_o           (rd_open),
        .rd_slot_o           (rd_slot),
        .frame_avail_o       (frame_avail_o),
        .stored_count_o      (stored_count_o),
        .missed_count_o      (missed_count_o)
    );

    frame_writer writer0 (
        .idelay_refclk       (idelay_refclk),
        .reset_idelay_refclk (reset_idelay_refclk),
        .pix_valid_i         (cam_i.valid),
        .pix_data_i          (cam_i.data),
        .frame_len_i         (frame_len_i),
        .wr_open_i           (wr_open),
        .wr_slot_i           (wr_slot),
        .mem_gnt_i           (wr_gnt),
        .mem_req_o           (wr_req),
        .mem_wdata_o         (wr_wdata),
        .busy_o              (writer_busy),
        .frame_written_o     (frame_written)
    );

    frame_reader reader0 (
        .idelay_refclk       (idelay_refclk),
        .reset_idelay_refclk (reset_idelay_refclk),
        .rd_open_i           (rd_open),
        .rd_slot_i           (rd_slot),
        .frame_len_i         (frame_len_i),
        .mem_gnt_i           (rd_gnt),
        .mem_rdata_i         (rd_data),
        .mem_rdata_valid_i   (rd_data_valid),
        .mem_req_o           (rd_req),
        .out_data_o          (out_data_o),
        .out_valid_o         (out_valid_o),
        .readout_done_o      (readout_done_o),
        .busy_o              (reader_busy)
    );

    mem_arbiter memarb0 (
        .idelay_refclk       (idelay_refclk),
        .reset_idelay_refclk (reset_idelay_refclk),
        .wr_req_i            (wr_req),
        .wr_wdata_i          (wr_wdata),
        .rd_req_i            (rd_req),
        .mem_rdata_i         (mem_rdata),
        .wr_gnt_o            (wr_gnt),
        .rd_gnt_o            (rd_gnt),
        .mem_req_o           (mem_req),
        .mem_wdata_o         (mem_wdata),
        .rd_data_o           (rd_data),
        .rd_data_valid_o     (rd_data_valid)
    );

    frame_mem mem0 (
        .idelay_refclk       (idelay_refclk),
        .req_i               (mem_req),
        .wdata_i             (mem_wdata),
        .rdata_o             (mem_rdata)
    );

endmodule

// File: cam_buf_vectors.txt
# frame   <length in words> [lcg seed]  camera frame, seed 79478 when left out
# readout                               host asks for the oldest stored frame
# wait    <cycles>                      idle, then counters are checked
readout                  # nothing stored yet, must stay silent
wait 20
frame 8 4660             # single frame round trip
wait 4
readout
wait 40
frame 16 101             # fill the ring
frame 64 202
frame 1 303
frame 5
frame 12 404             # every slot busy, dropped
wait 10
readout
wait 60
readout                  # long read races the next frame
frame 20 505
wait 160
readout
wait 20
readout
wait 30
readout
wait 60

// File: frame_mem.sv
module frame_mem
    import cam_buf_pkg::*;
(
    input  logic      idelay_refclk,
    input  mem_req_t  req_i,
    input  pix_word_t wdata_i,
    output pix_word_t rdata_o
);

    // whole frame store, one word per address
    pix_word_t mem [0:MEM_WORDS-1];

    // single port, write or read per cycle
    always_ff @(posedge idelay_refclk) begin
        if (req_i.req) begin
            if (req_i.we) begin
                mem[req_i.addr] <= wdata_i;
            end else begin
                rdata_o <= mem[req_i.addr];  // shows up next cycle
            end
        end
    end

endmodule

// File: frame_reader.sv
module frame_reader
    import cam_buf_pkg::*;
(
    input  logic       idelay_refclk,
    input  logic       reset_idelay_refclk,
    input  logic       rd_open_i,
    input  slot_t      rd_slot_i,
    input  frame_len_t frame_len_i,
    input  logic       mem_gnt_i,
    input  pix_word_t  mem_rdata_i,
    input  logic       mem_rdata_valid_i,
    output mem_req_t   mem_req_o,
    output pix_word_t  out_data_o,
    output logic       out_valid_o,
    output logic       readout_done_o,
    output logic       busy_o
);

    rd_state_e  state;
    slot_t      slot_q;      // slot being read
    frame_len_t len_q;       // words to read, caught at open
    frame_len_t iss_cnt;     // reads granted
    frame_len_t ret_cnt;     // words returned
    logic       last_issue;
    logic       last_ret;
    logic       last_ret_q;  // last word is on the outputs

    assign last_issue = mem_gnt_i && (iss_cnt == len_q - 1'b1);
    assign last_ret   = mem_rdata_valid_i && (ret_cnt == len_q - 1'b1);

    // ------------------------------------------------------------------
    // read requests, in address order
    // ------------------------------------------------------------------
    always_comb begin
        mem_req_o.req  = (state == RD_ISSUE);
        mem_req_o.we   = 1'b0;
        mem_req_o.addr = mem_addr_t'(slot_q * SLOT_WORDS) + mem_addr_t'(iss_cnt);
    end

    // stays busy through the done pulse so no new open overlaps it
    assign busy_o = (state != RD_IDLE) || readout_done_o;

    always_ff @(posedge idelay_refclk) begin
        out_data_o <= mem_rdata_i;
        if (state == RD_IDLE && rd_open_i) begin
            slot_q <= rd_slot_i;
            len_q  <= frame_len_i;
        end
    end

    always_ff @(posedge idelay_refclk) begin
        if (reset_idelay_refclk) begin
            state          <= RD_IDLE;
            iss_cnt        <= '0;
            ret_cnt        <= '0;
            out_valid_o    <= 1'b0;
            last_ret_q     <= 1'b0;
            readout_done_o <= 1'b0;
        end else begin
            out_valid_o    <= mem_rdata_valid_i;  // one word per strobe
            last_ret_q     <= last_ret;
            readout_done_o <= last_ret_q;         // cycle after last word
            if (mem_rdata_valid_i) ret_cnt <= ret_cnt + 1'b1;
            case (state)
                RD_IDLE: begin
                    if (rd_open_i) begin
                        state   <= RD_ISSUE;
                        iss_cnt <= '0;
                        ret_cnt <= '0;
                    end
                end
                RD_ISSUE: begin
                    if (mem_gnt_i) iss_cnt <= iss_cnt + 1'b1;
                    if (last_issue) state <= RD_DRAIN;
                end
                RD_DRAIN: begin
                    if (last_ret_q) state <= RD_IDLE;  // returns all in
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

endmodule

// File: frame_writer.sv
module frame_writer
    import cam_buf_pkg::*;
(
    input  logic       idelay_refclk,
    input  logic       reset_idelay_refclk,
    input  logic       pix_valid_i,
    input  pix_word_t  pix_data_i,
    input  frame_len_t frame_len_i,
    input  logic       wr_open_i,
    input  slot_t      wr_slot_i,
    input  logic       mem_gnt_i,
    output mem_req_t   mem_req_o,
    output pix_word_t  mem_wdata_o,
    output logic       busy_o,
    output logic       frame_written_o
);

    wr_state_e  state;
    slot_t      slot_q;    // slot of the open frame
    frame_len_t acc_cnt;   // words taken from camera
    frame_len_t com_cnt;   // words written to memory
    frame_len_t acc_base;  // accepted so far, 0 on the open cycle
    pix_word_t  fifo_mem [0:WFIFO_DEPTH-1];
    logic [$clog2(WFIFO_DEPTH)-1:0] fifo_wptr;
    logic [$clog2(WFIFO_DEPTH)-1:0] fifo_rptr;
    logic [$clog2(WFIFO_DEPTH):0]   fifo_cnt;
    logic       fifo_full;
    logic       fifo_empty;
    logic       push;
    logic       pop;
    logic       last_commit;

    assign fifo_full  = (fifo_cnt == WFIFO_DEPTH);
    assign fifo_empty = (fifo_cnt == '0);
    assign acc_base   = (state == WR_IDLE) ? '0 : acc_cnt;

    // a word may ride along with the open pulse itself
    assign push = pix_valid_i && (state == WR_ACTIVE || wr_open_i)
                  && !fifo_full && (acc_base < frame_len_i);
    assign pop  = mem_gnt_i;  // grant only comes while head is requested
    assign last_commit = pop && (com_cnt == frame_len_i - 1'b1);

    // ------------------------------------------------------------------
    // memory side, head of fifo at slot base + offset
    // ------------------------------------------------------------------
    always_comb begin
        mem_req_o.req  = (state == WR_ACTIVE) && !fifo_empty;
        mem_req_o.we   = 1'b1;
        mem_req_o.addr = mem_addr_t'(slot_q * SLOT_WORDS) + mem_addr_t'(com_cnt);
    end

    assign mem_wdata_o = fifo_mem[fifo_rptr];
    assign busy_o      = (state == WR_ACTIVE);

    // payload, no reset
    always_ff @(posedge idelay_refclk) begin
        if (push) begin
            fifo_mem[fifo_wptr] <= pix_data_i;
        end
        if (state == WR_IDLE && wr_open_i) begin
            slot_q <= wr_slot_i;
        end
    end

    always_ff @(posedge idelay_refclk) begin
        if (reset_idelay_refclk) begin
            state           <= WR_IDLE;
            acc_cnt         <= '0;
            com_cnt         <= '0;
            fifo_wptr       <= '0;
            fifo_rptr       <= '0;
            fifo_cnt        <= '0;
            frame_written_o <= 1'b0;
        end else begin
            frame_written_o <= last_commit;  // one cycle after last write
            if (push) fifo_wptr <= fifo_wptr + 1'b1;
            if (pop)  fifo_rptr <= fifo_rptr + 1'b1;
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            case (state)
                WR_IDLE: begin
                    if (wr_open_i) begin
                        state   <= WR_ACTIVE;
                        acc_cnt <= acc_base + frame_len_t'(push);
                        com_cnt <= '0;
                    end
                end
                WR_ACTIVE: begin
                    acc_cnt <= acc_cnt + frame_len_t'(push);
                    if (pop) com_cnt <= com_cnt + 1'b1;
                    if (last_commit) state <= WR_IDLE;  // fifo is empty by now
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule

// File: mem_arbiter.sv
module mem_arbiter
    import cam_buf_pkg::*;
(
    input  logic      idelay_refclk,
    input  logic      reset_idelay_refclk,
    input  mem_req_t  wr_req_i,
    input  pix_word_t wr_wdata_i,
    input  mem_req_t  rd_req_i,
    input  pix_word_t mem_rdata_i,
    output logic      wr_gnt_o,
    output logic      rd_gnt_o,
    output mem_req_t  mem_req_o,
    output pix_word_t mem_wdata_o,
    output pix_word_t rd_data_o,
    output logic      rd_data_valid_o
);

    arb_owner_e last_q;  // who got the port last time

    // ------------------------------------------------------------------
    // grant, same cycle as the request
    // ------------------------------------------------------------------
    always_comb begin
        wr_gnt_o = 1'b0;
        rd_gnt_o = 1'b0;
        if (wr_req_i.req && rd_req_i.req) begin
            // both asking, give it to the one not served last
            if (last_q == OWNER_WRITER) begin
                rd_gnt_o = 1'b1;
            end else begin
                wr_gnt_o = 1'b1;
            end
        end else if (wr_req_i.req) begin
            wr_gnt_o = 1'b1;
        end else if (rd_req_i.req) begin
            rd_gnt_o = 1'b1;
        end
    end

    // winner's access goes straight to the memory
    always_comb begin
        mem_req_o = '0;
        if (wr_gnt_o) begin
            mem_req_o = wr_req_i;
        end else if (rd_gnt_o) begin
            mem_req_o = rd_req_i;
        end
    end

    assign mem_wdata_o = wr_wdata_i;   // only the writer ever writes
    assign rd_data_o   = mem_rdata_i;  // qualified by rd_data_valid_o

    // ------------------------------------------------------------------
    // round robin pointer and read return tag
    // ------------------------------------------------------------------
    always_ff @(posedge idelay_refclk) begin
        if (reset_idelay_refclk) begin
            last_q          <= OWNER_READER;  // writer wins first tie
            rd_data_valid_o <= 1'b0;
        end else begin
            rd_data_valid_o <= rd_gnt_o && !rd_req_i.we;  // data lands next cycle
            if (wr_gnt_o) begin
                last_q <= OWNER_WRITER;
            end else if (rd_gnt_o) begin
                last_q <= OWNER_READER;
            end
        end
    end

endmodule

// File: sim.f
cam_buf_pkg.sv
frame_mem.sv
mem_arbiter.sv
frame_writer.sv
frame_reader.sv
buf_coordinator.sv
cam_buf_top.sv
tb_cam_buf_chk.sv
tb_cam_buf.sv

// File: tb_cam_buf.sv
module tb_cam_buf
    import cam_buf_pkg::*;
();

    localparam int          TIMEOUT_MARGIN = 1000;
    localparam int          AVAIL_WAIT     = 16;          // cycles allowed after last word
    localparam logic [31:0] LCG_MUL        = 32'd1103515245;
    localparam logic [31:0] LCG_INC        = 32'd12345;
    localparam logic [31:0] DEFAULT_SEED   = 32'd79478;
    localparam int          CMD_FRAME      = 0;
    localparam int          CMD_READOUT    = 1;
    localparam int          CMD_WAIT       = 2;

    logic       idelay_refclk;
    logic       reset_idelay_refclk;
    cam_beat_t  cam;
    frame_len_t frame_len;
    logic       readout_start;
    pix_word_t  out_data;
    logic       out_valid;
    logic       readout_done;
    logic       frame_avail;
    slot_cnt_t  stored_count;
    miss_cnt_t  missed_count;

    // reference model of the slot ring
    int         stored_lens[$];   // one entry per stored frame, oldest first
    pix_word_t  stored_words[$];  // their words, back to back
    pix_word_t  expect_q[$];      // words the running readout should return
    int         reads_inflight;
    int         missed_model;

    int         cmd_kind[$];
    int         cmd_a[$];
    int         cmd_b[$];
    int         budget;           // frame plus wait lengths
    int         timeout_limit;
    int         cycle_count;
    int         errors;
    int         assert_fails;
    bit         vectors_ok;

    cam_buf_top UUT (
        .idelay_refclk       (idelay_refclk),
        .reset_idelay_refclk (reset_idelay_refclk),
        .cam_i               (cam),
        .frame_len_i         (frame_len),
        .readout_start_i     (readout_start),
        .out_data_o          (out_data),
        .out_valid_o         (out_valid),
        .readout_done_o      (readout_done),
        .frame_avail_o       (frame_avail),
        .stored_count_o      (stored_count),
        .missed_count_o      (missed_count)
    );

    always #5 idelay_refclk = ~idelay_refclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * LCG_MUL + LCG_INC;  // mod 2^32
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("** Error: %s expected %h actual %h at cycle %0d",
                     name, exp_v, act_v, cycle_count);
        end
    endtask

    // ------------------------------------------------------------------
    // vector file, parsed up front so the run length is known
    // ------------------------------------------------------------------
    task automatic load_vectors(output bit ok);
        int    fd;
        int    n;
        int    a;
        int    b;
        string line;
        string cmd;
        ok = 1'b0;
        fd = $fopen("cam_buf_vectors.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %d %d", cmd, a, b);
                if (n < 3) b = DEFAULT_SEED;
                if (n >= 1 && cmd.substr(0, 0) != "#") begin
                    if (cmd == "frame" && n >= 2) begin
                        cmd_kind.push_back(CMD_FRAME);
                        budget += a;
                    end else if (cmd == "readout") begin
                        cmd_kind.push_back(CMD_READOUT);
                    end else if (cmd == "wait" && n >= 2) begin
                        cmd_kind.push_back(CMD_WAIT);
                        budget += a;
                    end else begin
                        errors++;
                        $display("unknown line in vector file: %s", line);
                    end
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------
    // camera side, one word every second cycle
    // ------------------------------------------------------------------
    task automatic send_frame(input int len, input logic [31:0] seed);
        pix_word_t   words[$];
        logic [31:0] state;
        bit          accepted;
        int          waited;
        int          k;
        accepted = (stored_lens.size() + reads_inflight) < NUM_SLOTS;  // ring has room
        state    = seed;
        @(posedge idelay_refclk);
        #1;
        frame_len       = frame_len_t'(len);
        cam.frame_start = 1'b1;
        @(posedge idelay_refclk);
        #1;
        cam.frame_start = 1'b0;
        for (k = 0; k < len; k++) begin
            state = lcg_next(state);
            words.push_back(state);
            cam.valid = 1'b1;
            cam.data  = state;
            @(posedge idelay_refclk);
            #1;
            cam.valid = 1'b0;  // spacing rule
            @(posedge idelay_refclk);
            #1;
        end
        if (accepted) begin
            waited = 0;
            @(negedge idelay_refclk);
            while (!frame_avail && waited < AVAIL_WAIT) begin
                @(negedge idelay_refclk);
                waited++;
            end
            if (!frame_avail) begin
                errors++;
                $display("frame_avail_o never pulsed for a %0d word frame", len);
            end else begin
                stored_lens.push_back(len);
                foreach (words[i]) stored_words.push_back(words[i]);
                if (reads_inflight == 0) begin
                    compare_word("stored_count_o", stored_lens.size(), stored_count);
                end
            end
        end else begin
            if (missed_model != 255) missed_model++;  // saturates like the DUT
            @(negedge idelay_refclk);
        end
        compare_word("missed_count_o", missed_model, missed_count);
    endtask

    // host request, honoured only with a stored frame and an idle reader
    task automatic start_readout();
        int len;
        @(posedge idelay_refclk);
        #1;
        if (stored_lens.size() != 0 && reads_inflight == 0) begin
            len       = stored_lens.pop_front();
            frame_len = frame_len_t'(len);  // reader latches length at open
            repeat (len) expect_q.push_back(stored_words.pop_front());
            reads_inflight++;
        end
        readout_start = 1'b1;
        @(posedge idelay_refclk);
        #1;
        readout_start = 1'b0;
    endtask

    task automatic idle_wait(input int cycles);
        repeat (cycles) @(posedge idelay_refclk);
        @(negedge idelay_refclk);
        if (reads_inflight != 0 || expect_q.size() != 0) begin
            errors++;
            $display("readout_done_o missing, %0d words still outstanding", expect_q.size());
            reads_inflight = 0;
            expect_q.delete();
        end
        compare_word("stored_count_o", stored_lens.size(), stored_count);
        compare_word("missed_count_o", missed_model, missed_count);
    endtask

    // ------------------------------------------------------------------
    // output monitor, sampled mid cycle
    // ------------------------------------------------------------------
    always @(negedge idelay_refclk) begin
        if (!reset_idelay_refclk && out_valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("out_valid_o pulsed while no readout word was expected");
            end else begin
                compare_word("out_data_o", expect_q.pop_front(), out_data);
            end
        end
        if (!reset_idelay_refclk && readout_done) begin
            if (reads_inflight == 0) begin
                errors++;
                $display("readout_done_o pulsed with no readout running");
            end else begin
                if (expect_q.size() != 0) begin
                    errors++;
                    $display("readout_done_o came %0d words early", expect_q.size());
                    expect_q.delete();
                end
                reads_inflight--;
            end
        end
    end

    always @(posedge idelay_refclk) begin
        cycle_count++;
        if (timeout_limit != 0 && cycle_count > timeout_limit) begin
            $display("timeout, run still going after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        idelay_refclk       = 1'b0;
        reset_idelay_refclk = 1'b1;
        cam                 = '0;
        frame_len           = frame_len_t'(1);
        readout_start       = 1'b0;
        load_vectors(vectors_ok);
        if (!vectors_ok) begin
            $display("cannot open cam_buf_vectors.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            timeout_limit = budget * 4 + TIMEOUT_MARGIN;
            repeat (10) @(posedge idelay_refclk);
            #1;
            reset_idelay_refclk = 1'b0;
            @(negedge idelay_refclk);
            compare_word("out_valid_o", 0, out_valid);  // reset values
            compare_word("readout_done_o", 0, readout_done);
            compare_word("frame_avail_o", 0, frame_avail);
            compare_word("stored_count_o", 0, stored_count);
            compare_word("missed_count_o", 0, missed_count);
            foreach (cmd_kind[i]) begin
                case (cmd_kind[i])
                    CMD_FRAME:   send_frame(cmd_a[i], cmd_b[i]);
                    CMD_READOUT: start_readout();
                    default:     idle_wait(cmd_a[i]);
                endcase
            end
            repeat (4) @(posedge idelay_refclk);
            assert_fails = UUT.chk0.fail_count;
            $display("check errors: %0d, assertion failures: %0d", errors, assert_fails);
            if (errors == 0 && assert_fails == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

// File: tb_cam_buf_chk.sv
module tb_cam_buf_chk
    import cam_buf_pkg::*;
(
    input logic      idelay_refclk,
    input logic      reset_idelay_refclk,
    input logic      out_valid_o,
    input logic      readout_done_o,
    input slot_cnt_t stored_count_o,
    input miss_cnt_t missed_count_o
);

    int fail_count = 0;  // picked up by the testbench at the end

    // ------------------------------------------------------------------
    // output protocol
    // ------------------------------------------------------------------
    quiet_in_reset: assert property (
        @(posedge idelay_refclk) reset_idelay_refclk |=> !out_valid_o
    ) else begin
        $error("out_valid_o high during reset");
        fail_count++;
    end

    done_after_last_word: assert property (
        @(posedge idelay_refclk) disable iff (reset_idelay_refclk)
        !(readout_done_o && out_valid_o)
    ) else begin
        $error("readout_done_o together with out_valid_o");
        fail_count++;
    end

    // ------------------------------------------------------------------
    // counters
    // ------------------------------------------------------------------
    miss_monotonic: assert property (
        @(posedge idelay_refclk) disable iff (reset_idelay_refclk)
        missed_count_o >= $past(missed_count_o)
    ) else begin
        $error("missed_count_o went down");
        fail_count++;
    end

    stored_bounded: assert property (
        @(posedge idelay_refclk) disable iff (reset_idelay_refclk)
        stored_count_o <= slot_cnt_t'(NUM_SLOTS)  // never more than the ring
    ) else begin
        $error("stored_count_o above slot count");
        fail_count++;
    end

endmodule

bind cam_buf_top tb_cam_buf_chk chk0 (
    .idelay_refclk       (idelay_refclk),
    .reset_idelay_refclk (reset_idelay_refclk),
    .out_valid_o         (out_valid_o),
    .readout_done_o      (readout_done_o),
    .stored_count_o      (stored_count_o),
    .missed_count_o      (missed_count_o)
);
